/* src/cachePkg.sv */
package cachePkg;

    // cache geometry
    localparam int numWays    = 2;
    localparam int numSets    = 16;
    localparam int setBits    = 4;
    localparam int offsetBits = 3;     // byte within a doubleword
    localparam int tagBits    = 57;

    // address split: tag | set | offset
    localparam int setLsb  = offsetBits;
    localparam int setMsb  = offsetBits + setBits - 1;
    localparam int tagLsb  = offsetBits + setBits;
    localparam int addrMsb = tagLsb + tagBits - 1;

    typedef logic [63:0]         addrT;
    typedef logic [63:0]         wordT;
    typedef logic [tagBits-1:0]  tagT;
    typedef logic [setBits-1:0]  setT;
    typedef logic [4:0]          memOpT;

    // operation fields, size sits in bits 1:0
    localparam int opStoreBit    = 4;
    localparam int opLoadBit     = 3;
    localparam int opUnsignedBit = 2;

    localparam logic [1:0] sizeByte = 2'b00;
    localparam logic [1:0] sizeHalf = 2'b01;
    localparam logic [1:0] sizeWord = 2'b10;

    typedef enum logic [1:0] {
        idle,
        reqHigh,    // request out, waiting for ack
        ackWait     // line written, waiting for ack to drop
    } refillStateT;

    // byte offset rounded down to the access size
    function automatic logic [offsetBits-1:0] alignOffset(input memOpT op,
                                                          input logic [offsetBits-1:0] offset);
        case (op[1:0])
            sizeByte: return offset;
            sizeHalf: return {offset[2:1], 1'b0};
            sizeWord: return {offset[2], 2'b00};
            default:  return '0;     // doubleword
        endcase
    endfunction

endpackage

/* src/dataArray.sv */
`timescale 1ns/10ps

module dataArray import cachePkg::*; (
    input  logic  clk,
    input  logic  enable,
    input  memOpT op1,
    input  memOpT op2,
    input  addrT  addr1,
    input  addrT  addr2,
    input  wordT  storeData1,
    input  wordT  storeData2,
    input  logic  hit1,
    input  logic  hit2,
    input  logic  hitWay1,
    input  logic  hitWay2,
    input  logic  stall,
    input  logic  fillEn,
    input  addrT  fillAddr,
    input  logic  fillWay,
    input  wordT  fillData,
    output wordT  rawData1,
    output wordT  rawData2
);

    wordT       dataMem [numWays][numSets];
    setT        set1;
    setT        set2;
    logic [7:0] mask1;
    logic [7:0] mask2;
    wordT       aligned1;
    wordT       aligned2;
    wordT       readWay2;
    logic       sameAddrStores;
    logic       forward1;
    logic       write1;
    logic       write2;

    function automatic logic [7:0] byteMask(input memOpT op, input logic [offsetBits-1:0] offset);
        logic [7:0] sizeMask;
        case (op[1:0])
            sizeByte: sizeMask = 8'h01;
            sizeHalf: sizeMask = 8'h03;
            sizeWord: sizeMask = 8'h0f;
            default:  sizeMask = 8'hff;
        endcase
        return sizeMask << alignOffset(op, offset);
    endfunction

    function automatic wordT mergeBytes(input wordT base, input wordT newData,
                                        input logic [7:0] mask);
        wordT merged;
        merged = base;
        for (int i = 0; i < 8; i++) begin
            if (mask[i]) begin
                merged[8*i +: 8] = newData[8*i +: 8];
            end
        end
        return merged;
    endfunction

    assign set1     = addr1[setMsb:setLsb];
    assign set2     = addr2[setMsb:setLsb];
    assign mask1    = byteMask(op1, addr1[offsetBits-1:0]);
    assign mask2    = byteMask(op2, addr2[offsetBits-1:0]);
    assign aligned1 = storeData1 << {alignOffset(op1, addr1[offsetBits-1:0]), 3'b000};
    assign aligned2 = storeData2 << {alignOffset(op2, addr2[offsetBits-1:0]), 3'b000};

    // lane 2 wins outright on an identical store address
    assign sameAddrStores = op1[opStoreBit] && op2[opStoreBit] && (addr1 == addr2);
    assign forward1 = enable && op1[opStoreBit] && !sameAddrStores
                      && (addr1[addrMsb:setLsb] == addr2[addrMsb:setLsb]);

    assign rawData1 = dataMem[hitWay1][set1];
    assign readWay2 = dataMem[hitWay2][set2];
    assign rawData2 = forward1 ? mergeBytes(readWay2, aligned1, mask1) : readWay2;

    assign write1 = enable && !stall && hit1 && op1[opStoreBit] && !sameAddrStores;
    assign write2 = enable && !stall && hit2 && op2[opStoreBit];

    always_ff @(posedge clk) begin
        if (fillEn) begin
            dataMem[fillWay][fillAddr[setMsb:setLsb]] <= fillData;
        end else begin
            if (write1) begin
                dataMem[hitWay1][set1] <= mergeBytes(rawData1, aligned1, mask1);
            end
            if (write2) begin    // base already holds forwarded lane 1 bytes
                dataMem[hitWay2][set2] <= mergeBytes(rawData2, aligned2, mask2);
            end
        end
    end

endmodule

/* src/dualLaneCache.sv */
`timescale 1ns/10ps

module dualLaneCache import cachePkg::*; (
    input  logic  clk,
    input  logic  arstN,
    input  logic  enable,
    input  memOpT op1,
    input  memOpT op2,
    input  addrT  addr1,
    input  addrT  addr2,
    input  wordT  storeData1,
    input  wordT  storeData2,
    output wordT  loadData1,
    output wordT  loadData2,
    output logic  stall,
    output logic  refillReq,
    output addrT  refillAddr,
    input  logic  refillAck,
    input  wordT  refillData
);

    logic hit1;
    logic hit2;
    logic hitWay1;
    logic hitWay2;
    logic victimWay1;
    logic victimWay2;
    logic fillEn;
    addrT fillAddr;
    logic fillWay;
    wordT fillData;
    wordT rawData1;
    wordT rawData2;

    tagArray tags (
        .clk, .arstN, .enable, .op1, .op2, .addr1, .addr2, .stall,
        .fillEn, .fillAddr, .fillWay,
        .hit1, .hit2, .hitWay1, .hitWay2, .victimWay1, .victimWay2
    );

    dataArray data (
        .clk, .enable, .op1, .op2, .addr1, .addr2, .storeData1, .storeData2,
        .hit1, .hit2, .hitWay1, .hitWay2, .stall,
        .fillEn, .fillAddr, .fillWay, .fillData,
        .rawData1, .rawData2
    );

    refillControl refill (
        .clk, .arstN, .enable, .op1, .op2, .addr1, .addr2,
        .hit1, .hit2, .victimWay1, .victimWay2, .refillAck, .refillData,
        .stall, .refillReq, .refillAddr, .fillEn, .fillAddr, .fillWay, .fillData
    );

    loadAlign align1 (
        .op       (op1),
        .offset   (addr1[offsetBits-1:0]),
        .rawData  (rawData1),
        .loadData (loadData1)
    );

    loadAlign align2 (
        .op       (op2),
        .offset   (addr2[offsetBits-1:0]),
        .rawData  (rawData2),
        .loadData (loadData2)
    );

endmodule

/* src/loadAlign.sv */
`timescale 1ns/10ps

module loadAlign import cachePkg::*; (
    input  memOpT                  op,
    input  logic [offsetBits-1:0]  offset,
    input  wordT                   rawData,
    output wordT                   loadData
);

    wordT shifted;
    logic unsignedLoad;

    // field moved down to bit 0
    assign shifted      = rawData >> {alignOffset(op, offset), 3'b000};
    assign unsignedLoad = op[opUnsignedBit];

    always_comb begin
        case (op[1:0])
            sizeByte: begin
                loadData = unsignedLoad ? {56'b0, shifted[7:0]}
                                        : {{56{shifted[7]}}, shifted[7:0]};
            end
            sizeHalf: begin
                loadData = unsignedLoad ? {48'b0, shifted[15:0]}
                                        : {{48{shifted[15]}}, shifted[15:0]};
            end
            sizeWord: begin
                loadData = unsignedLoad ? {32'b0, shifted[31:0]}
                                        : {{32{shifted[31]}}, shifted[31:0]};
            end
            default: begin
                loadData = rawData;    // ld, nothing to extend
            end
        endcase
    end

endmodule

/* src/refillControl.sv */
`timescale 1ns/10ps

module refillControl import cachePkg::*; (
    input  logic  clk,
    input  logic  arstN,
    input  logic  enable,
    input  memOpT op1,
    input  memOpT op2,
    input  addrT  addr1,
    input  addrT  addr2,
    input  logic  hit1,
    input  logic  hit2,
    input  logic  victimWay1,
    input  logic  victimWay2,
    input  logic  refillAck,
    input  wordT  refillData,
    output logic  stall,
    output logic  refillReq,
    output addrT  refillAddr,
    output logic  fillEn,
    output addrT  fillAddr,
    output logic  fillWay,
    output wordT  fillData
);

    refillStateT state;
    addrT        lineAddr;
    logic        lineWay;
    logic        miss1;
    logic        miss2;

    assign miss1 = enable && (op1[opLoadBit] || op1[opStoreBit]) && !hit1;
    assign miss2 = enable && (op2[opLoadBit] || op2[opStoreBit]) && !hit2;

    // held until the handshake is back in idle
    assign stall = enable && (miss1 || miss2 || (state != idle));

    assign refillReq  = (state == reqHigh);
    assign refillAddr = lineAddr;
    assign fillEn     = refillReq && refillAck;    // one cycle, ack seen
    assign fillAddr   = lineAddr;
    assign fillWay    = lineWay;
    assign fillData   = refillData;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state <= idle;
        end else begin
            case (state)
                idle: begin
                    if (miss1 || miss2) begin
                        state <= reqHigh;
                    end
                end
                reqHigh: begin
                    if (refillAck) begin
                        state <= ackWait;
                    end
                end
                ackWait: begin
                    if (!refillAck) begin
                        state <= idle;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    // lane 1 is serviced first
    always_ff @(posedge clk) begin
        if (state == idle) begin
            if (miss1) begin
                lineAddr <= {addr1[addrMsb:setLsb], {offsetBits{1'b0}}};
                lineWay  <= victimWay1;
            end else if (miss2) begin
                lineAddr <= {addr2[addrMsb:setLsb], {offsetBits{1'b0}}};
                lineWay  <= victimWay2;
            end
        end
    end

endmodule

/* src/tagArray.sv */
`timescale 1ns/10ps

module tagArray import cachePkg::*; (
    input  logic  clk,
    input  logic  arstN,
    input  logic  enable,
    input  memOpT op1,
    input  memOpT op2,
    input  addrT  addr1,
    input  addrT  addr2,
    input  logic  stall,
    input  logic  fillEn,
    input  addrT  fillAddr,
    input  logic  fillWay,
    output logic  hit1,
    output logic  hit2,
    output logic  hitWay1,
    output logic  hitWay2,
    output logic  victimWay1,
    output logic  victimWay2
);

    tagT                             tagMem [numWays][numSets];
    logic [numWays-1:0][numSets-1:0] validBits;
    logic [numSets-1:0]              lruBits;    // way to replace next

    setT                set1;
    setT                set2;
    setT                fillSet;
    tagT                tag1;
    tagT                tag2;
    logic [numWays-1:0] wayHit1;
    logic [numWays-1:0] wayHit2;
    logic               touch1;
    logic               touch2;

    assign set1    = addr1[setMsb:setLsb];
    assign set2    = addr2[setMsb:setLsb];
    assign fillSet = fillAddr[setMsb:setLsb];
    assign tag1    = addr1[addrMsb:tagLsb];
    assign tag2    = addr2[addrMsb:tagLsb];

    for (genvar w = 0; w < numWays; w++) begin : gWay
        assign wayHit1[w] = validBits[w][set1] && (tagMem[w][set1] == tag1);
        assign wayHit2[w] = validBits[w][set2] && (tagMem[w][set2] == tag2);
    end

    assign hit1       = |wayHit1;
    assign hit2       = |wayHit2;
    assign hitWay1    = wayHit1[1];
    assign hitWay2    = wayHit2[1];
    assign victimWay1 = lruBits[set1];
    assign victimWay2 = lruBits[set2];

    // only completing operations refresh the LRU
    assign touch1 = enable && !stall && hit1 && (op1[opLoadBit] || op1[opStoreBit]);
    assign touch2 = enable && !stall && hit2 && (op2[opLoadBit] || op2[opStoreBit]);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            validBits <= '0;
            lruBits   <= '0;
        end else if (fillEn) begin
            validBits[fillWay][fillSet] <= 1'b1;
            lruBits[fillSet]            <= ~fillWay;    // filled way is now recent
        end else begin
            if (touch1) begin
                lruBits[set1] <= ~hitWay1;
            end
            if (touch2) begin
                lruBits[set2] <= ~hitWay2;    // lane 2 last, wins on a shared set
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fillEn) begin
            tagMem[fillWay][fillSet] <= fillAddr[addrMsb:tagLsb];
        end
    end

endmodule

/* tb.f */
src/cachePkg.sv
src/tagArray.sv
src/dataArray.sv
src/loadAlign.sv
src/refillControl.sv
src/dualLaneCache.sv
verification/refillResponder.sv
verification/cacheTb.sv

/* verification/cacheTb.sv */
`timescale 1ns/10ps

module cacheTb import cachePkg::*; ();

    localparam int   clkPeriod   = 8;
    localparam int   sampleDelay = 2;    // quarter period after the falling edge
    localparam int   resetCycles = 16;
    localparam int   maxRows     = 32;
    localparam wordT memKey      = 64'h5a3c_96e1_8f78_c4b2;

    localparam memOpT opNone = 5'b00000;
    localparam memOpT ldB    = 5'b01000;
    localparam memOpT ldH    = 5'b01001;
    localparam memOpT ldW    = 5'b01010;
    localparam memOpT ldD    = 5'b01011;
    localparam memOpT ldBU   = 5'b01100;
    localparam memOpT ldHU   = 5'b01101;
    localparam memOpT ldWU   = 5'b01110;
    localparam memOpT stB    = 5'b10000;
    localparam memOpT stH    = 5'b10001;
    localparam memOpT stW    = 5'b10010;
    localparam memOpT stD    = 5'b10011;

    // lines by set: A set 1, S set 2, F set 3, lru* set 5, D set 6, E set 7, G set 9
    localparam addrT lineA = 64'h8000_0000_0001_0008;
    localparam addrT lineS = 64'h0000_0000_0002_0010;
    localparam addrT lineF = 64'h0000_0000_0003_0018;
    localparam addrT lruA  = 64'h0000_0000_0000_0828;
    localparam addrT lruB  = 64'h0000_0000_0000_1028;
    localparam addrT lruC  = 64'h0000_0000_0000_1828;
    localparam addrT lineD = 64'h0000_0000_0400_0030;
    localparam addrT lineE = 64'h0000_0000_0800_0038;
    localparam addrT lineG = 64'h0000_0000_0005_0048;

    logic  clk;
    logic  arstN;
    logic  enable;
    memOpT op1;
    memOpT op2;
    addrT  addr1;
    addrT  addr2;
    wordT  storeData1;
    wordT  storeData2;
    wordT  loadData1;
    wordT  loadData2;
    logic  stall;
    logic  refillReq;
    addrT  refillAddr;
    logic  refillAck;
    wordT  refillData;

    string rowName  [maxRows];
    memOpT rowOp1   [maxRows];
    memOpT rowOp2   [maxRows];
    addrT  rowAddr1 [maxRows];
    addrT  rowAddr2 [maxRows];
    wordT  rowData1 [maxRows];
    wordT  rowData2 [maxRows];
    wordT  rowLoad1 [maxRows];
    wordT  rowLoad2 [maxRows];
    int    rowMiss  [maxRows];    // 0 all hit, else lane refilled first
    int    rowCount;

    addrT  shadowLine [maxRows];    // lines changed by stores
    wordT  shadowWord [maxRows];
    int    shadowCount;

    int    errorCount;
    int    failedRows;
    int    cycleCount;
    logic  tableReady;

    dualLaneCache UUT (
        .clk, .arstN, .enable, .op1, .op2, .addr1, .addr2, .storeData1, .storeData2,
        .loadData1, .loadData2, .stall, .refillReq, .refillAddr, .refillAck, .refillData
    );

    refillResponder memory (
        .clk, .arstN, .lineKey (memKey), .refillReq, .refillAddr, .refillAck, .refillData
    );

    function automatic addrT lineOf(input addrT addr);
        return {addr[63:3], 3'b000};
    endfunction

    function automatic int fieldBytes(input memOpT op);
        return 1 << op[1:0];
    endfunction

    // offset rounded down to the access size
    function automatic int fieldStart(input memOpT op, input addrT addr);
        return addr[2:0] & ~(fieldBytes(op) - 1);
    endfunction

    function automatic wordT lineValue(input addrT addr);
        for (int i = 0; i < shadowCount; i++) begin
            if (shadowLine[i] == lineOf(addr)) begin
                return shadowWord[i];
            end
        end
        return lineOf(addr) ^ memKey;    // untouched line, refill rule
    endfunction

    function automatic wordT expectLoad(input memOpT op, input addrT addr);
        wordT field;
        wordT keep;
        int   bits;
        bits  = 8 * fieldBytes(op);
        field = lineValue(addr) >> (8 * fieldStart(op, addr));
        if (bits == 64) begin
            return field;
        end
        keep  = (64'd1 << bits) - 1;
        field = field & keep;
        if (!op[opUnsignedBit] && field[bits-1]) begin
            field = field | ~keep;
        end
        return field;
    endfunction

    task automatic applyStore(input memOpT op, input addrT addr, input wordT data);
        wordT word;
        int   slot;
        word = lineValue(addr);
        for (int i = 0; i < fieldBytes(op); i++) begin
            word[8 * (fieldStart(op, addr) + i) +: 8] = data[8 * i +: 8];
        end
        slot = shadowCount;
        for (int i = 0; i < shadowCount; i++) begin
            if (shadowLine[i] == lineOf(addr)) begin
                slot = i;
            end
        end
        if (slot == shadowCount) begin
            shadowCount++;
        end
        shadowLine[slot] = lineOf(addr);
        shadowWord[slot] = word;
    endtask

    task automatic addRow(input string name, input memOpT op1In, input addrT addr1In,
                          input wordT data1In, input memOpT op2In, input addrT addr2In,
                          input wordT data2In, input int miss);
        rowName[rowCount]  = name;
        rowOp1[rowCount]   = op1In;
        rowOp2[rowCount]   = op2In;
        rowAddr1[rowCount] = addr1In;
        rowAddr2[rowCount] = addr2In;
        rowData1[rowCount] = data1In;
        rowData2[rowCount] = data2In;
        rowMiss[rowCount]  = miss;
        rowLoad1[rowCount] = expectLoad(op1In, addr1In);
        // lane 1 store lands first, lane 2 wins on the same address
        if (op1In[opStoreBit] && !(op2In[opStoreBit] && addr1In == addr2In)) begin
            applyStore(op1In, addr1In, data1In);
        end
        rowLoad2[rowCount] = expectLoad(op2In, addr2In);
        if (op2In[opStoreBit]) begin
            applyStore(op2In, addr2In, data2In);
        end
        rowCount++;
    endtask

    task automatic buildTable();
        addRow("ld miss", ldD, lineA, 0, opNone, 0, 0, 1);
        addRow("ld repeat hit", ldD, lineA, 0, opNone, 0, 0, 0);
        addRow("lb / lbu", ldB, lineA + 1, 0, ldBU, lineA + 1, 0, 0);
        addRow("lh / lhu", ldH, lineA + 4, 0, ldHU, lineA + 4, 0, 0);
        addRow("lw / lwu", ldW, lineA, 0, ldWU, lineA, 0, 0);
        addRow("unaligned lwu / lh", ldWU, lineA + 6, 0, ldH, lineA + 7, 0, 0);
        addRow("sb miss", stB, lineS + 3, 64'hffee_ddcc_bbaa_9988, opNone, 0, 0, 1);
        addRow("ld / sh", ldD, lineS, 0, stH, lineS + 6, 64'h7777_6666_5555_4321, 0);
        addRow("ld / sw", ldD, lineS, 0, stW, lineS + 4, 64'h1357_9bdf_0246_8ace, 0);
        addRow("ld / sd", ldD, lineS, 0, stD, lineS, 64'hfedc_ba98_7654_3210, 0);
        addRow("ld after sd", ldD, lineS, 0, ldB, lineS + 5, 0, 0);
        addRow("sw forward on miss", stW, lineF + 4, 64'h1122_3344, ldD, lineF, 0, 1);
        addRow("sh same address", stH, lineF + 2, 64'haaaa, stH, lineF + 2, 64'hbbbb, 0);
        addRow("ld after sh pair", ldD, lineF, 0, ldHU, lineF + 2, 0, 0);
        addRow("sb forward lbu", stB, lineF + 7, 64'h80, ldBU, lineF + 7, 0, 0);
        addRow("sd forward lw", stD, lineF, 64'h0123_4567_89ab_cdef, ldW, lineF + 4, 0, 0);
        addRow("lru load A", ldD, lruA, 0, opNone, 0, 0, 1);
        addRow("lru load B", ldD, lruB, 0, opNone, 0, 0, 1);
        addRow("lru A again", ldD, lruA, 0, opNone, 0, 0, 0);
        addRow("lru C evicts B", ldD, lruC, 0, opNone, 0, 0, 1);
        addRow("lru A still hits", ldD, lruA, 0, opNone, 0, 0, 0);
        addRow("lru B refills", ldD, lruB, 0, opNone, 0, 0, 1);
        addRow("dual miss", ldD, lineD, 0, ldD, lineE, 0, 1);
        addRow("dual hit", ldHU, lineD + 2, 0, ldW, lineE + 4, 0, 0);
        addRow("lane 2 miss only", ldD, lineA, 0, ldB, lineG + 3, 0, 2);
    endtask

    task automatic runRow(input int r);
        logic sawReq;
        addrT firstReq;
        addrT missLine;
        int   errorsBefore;
        errorsBefore = errorCount;
        sawReq       = 1'b0;
        firstReq     = '0;
        missLine     = (rowMiss[r] == 2) ? lineOf(rowAddr2[r]) : lineOf(rowAddr1[r]);
        enable       = 1'b1;
        op1          = rowOp1[r];
        op2          = rowOp2[r];
        addr1        = rowAddr1[r];
        addr2        = rowAddr2[r];
        storeData1   = rowData1[r];
        storeData2   = rowData2[r];
        #sampleDelay;
        assert (rowMiss[r] != 0 || !stall) else begin
            $display("row %0d: stall was raised on an access that should hit", r);
            errorCount++;
        end
        while (stall) begin
            if (refillReq && !sawReq) begin
                sawReq   = 1'b1;
                firstReq = refillAddr;
            end
            @(negedge clk);
            #sampleDelay;
        end
        if (rowMiss[r] != 0) begin
            assert (sawReq) else begin
                $display("row %0d: the miss finished without any refill request", r);
                errorCount++;
            end
            assert (!sawReq || firstReq == missLine) else begin
                $display("CHECK FAILED refillAddr row %0d: got %h, expected %h",
                         r, firstReq, missLine);
                errorCount++;
            end
        end
        if (rowOp1[r][opLoadBit]) begin
            assert (loadData1 === rowLoad1[r]) else begin
                $display("CHECK FAILED loadData1 row %0d: got %h, expected %h",
                         r, loadData1, rowLoad1[r]);
                errorCount++;
            end
        end
        if (rowOp2[r][opLoadBit]) begin
            assert (loadData2 === rowLoad2[r]) else begin
                $display("CHECK FAILED loadData2 row %0d: got %h, expected %h",
                         r, loadData2, rowLoad2[r]);
                errorCount++;
            end
        end
        if (errorCount == errorsBefore) begin
            $display("row %0d %s: pass", r, rowName[r]);
        end else begin
            failedRows++;
            $display("row %0d %s: FAIL", r, rowName[r]);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever begin
            #(clkPeriod / 2) clk = ~clk;
        end
    end

    // cycle budget from the table length
    initial begin
        cycleCount = 0;
        wait (tableReady);
        while (cycleCount < rowCount * 40 + resetCycles) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("TIMEOUT: the run did not finish within %0d clock cycles", cycleCount);
        $display("Done: errors found");
        $finish;
    end

    initial begin
        tableReady  = 1'b0;
        rowCount    = 0;
        shadowCount = 0;
        errorCount  = 0;
        failedRows  = 0;
        arstN       = 1'b0;
        enable      = 1'b0;
        op1         = opNone;
        op2         = opNone;
        addr1       = '0;
        addr2       = '0;
        storeData1  = '0;
        storeData2  = '0;
        buildTable();
        tableReady = 1'b1;
        repeat (resetCycles) @(negedge clk);
        arstN = 1'b1;
        @(negedge clk);
        for (int r = 0; r < rowCount; r++) begin
            runRow(r);
            @(negedge clk);
        end
        enable = 1'b0;
        $display("rows: %0d, failed rows: %0d, errors: %0d", rowCount, failedRows, errorCount);
        if (errorCount == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

/* verification/refillResponder.sv */
`timescale 1ns/10ps

// next-level memory model, answers each refill with the line address xor a key
module refillResponder import cachePkg::*; (
    input  logic clk,
    input  logic arstN,
    input  wordT lineKey,
    input  logic refillReq,
    input  addrT refillAddr,
    output logic refillAck,
    output wordT refillData
);

    int waitCount;

    always @(negedge clk or negedge arstN) begin
        if (!arstN) begin
            refillAck  <= 1'b0;
            refillData <= '0;
            waitCount  <= 0;
        end else if (refillReq && !refillAck) begin
            if (waitCount < refillAddr[4:3]) begin    // latency varies with the line
                waitCount <= waitCount + 1;
            end else begin
                refillData <= {refillAddr[63:3], 3'b000} ^ lineKey;
                refillAck  <= 1'b1;
                waitCount  <= 0;
            end
        end else if (!refillReq && refillAck) begin
            refillAck <= 1'b0;    // return to zero
        end
    end

endmodule
